/* src/rvfi_cmp_pkg.sv */
/*
  Shared types for the RVFI retirement checker: packet layout, mismatch
  field indices, compare result and log state. Imported by every stage.
*/
package rvfi_cmp_pkg;

  localparam int XLEN   = 32;
  localparam int CNT_W  = 16;

  // widths of the narrow RVFI fields
  localparam int DBG_W      = 3;
  localparam int NMIP_W     = 2;
  localparam int INTR_W     = 11;
  localparam int MODE_W     = 2;
  localparam int REG_ADDR_W = 5;
  localparam int MEM_MASK_W = 4;

  // bit position of each field in the mismatch mask
  typedef enum logic [4:0] {
    FLD_VALID,
    FLD_PC,
    FLD_INSN,
    FLD_TRAP,
    FLD_HALT,
    FLD_DBG,
    FLD_DBG_MODE,
    FLD_NMIP,
    FLD_INTR,
    FLD_MODE,
    FLD_RD1_ADDR,
    FLD_RD1_WDATA,
    FLD_MEM_RMASK,
    FLD_MEM_WMASK,
    FLD_MEM_ADDR,
    FLD_MEM_WDATA,
    FLD_MEM_RDATA,
    FLD_PC_WDATA
  } rvfi_field_e;

  // last entry of the field enum sets the mask width
  localparam int NUM_FIELDS = int'(FLD_PC_WDATA) + 1;

  typedef enum logic {
    LOG_CLEAN,
    LOG_FAULTED
  } log_state_e;

  // one retired instruction as seen on RVFI
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       insn;
    logic                  trap;
    logic                  halt;
    logic [DBG_W-1:0]      dbg;
    logic                  dbg_mode;
    logic [NMIP_W-1:0]     nmip;
    // bit 0 flags the interrupt, cause sits in the upper bits
    logic [INTR_W-1:0]     intr;
    logic [MODE_W-1:0]     mode;
    logic [REG_ADDR_W-1:0] rd1_addr;
    logic [XLEN-1:0]       rd1_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [MEM_MASK_W-1:0] mem_rmask;
    logic [MEM_MASK_W-1:0] mem_wmask;
    logic [XLEN-1:0]       mem_wdata;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       pc_wdata;
  } rvfi_pkt_t;

  // outcome of one compare, pc is the core pc_rdata
  typedef struct packed {
    logic                  valid;
    logic [NUM_FIELDS-1:0] mask;
    logic [XLEN-1:0]       pc;
  } cmp_result_t;

endpackage

/* src/rvfi_core_align.sv */
/*
  Delays the core RVFI packet by one cycle so it lines up with the
  reference model packet of the same instruction.
*/
module rvfi_core_align
  import rvfi_cmp_pkg::*;
(
  input  logic      rvfi_core,
  input  logic      rst_i,
  input  rvfi_pkt_t core_pkt_i,
  output rvfi_pkt_t aligned_pkt_o
);

  // payload follows the input every cycle, only valid is cleared
  always_ff @(posedge rvfi_core) begin
    aligned_pkt_o <= core_pkt_i;
    if (rst_i) begin
      aligned_pkt_o.valid <= 1'b0;
    end
  end

  // an unknown valid would poison every downstream counter
  a_aligned_valid_known: assert property (
    @(posedge rvfi_core) disable iff (rst_i)
    !$isunknown(aligned_pkt_o.valid)
  );

endmodule

/* src/rvfi_field_cmp.sv */
/*
  Compares the aligned core packet with the reference model packet field
  by field and registers the mismatch mask together with the core PC.
*/
module rvfi_field_cmp
  import rvfi_cmp_pkg::*;
(
  input  logic        rvfi_core,
  input  logic        rst_i,
  input  rvfi_pkt_t   core_pkt_i,
  input  rvfi_pkt_t   rm_pkt_i,
  output cmp_result_t result_o
);

  logic [NUM_FIELDS-1:0] mask_d;
  logic                  cmp_valid;
  logic                  core_rd;
  logic                  core_wr;
  logic [NUM_FIELDS-1:0] data_mask;

  assign cmp_valid = core_pkt_i.valid || rm_pkt_i.valid;

  // memory qualifiers come from the core side
  assign core_rd = core_pkt_i.mem_rmask[3:0] != '0;
  assign core_wr = core_pkt_i.mem_wmask[3:0] != '0;

  always_comb begin
    mask_d = '0;
    // core retired something the model did not
    mask_d[FLD_VALID] = core_pkt_i.valid && !rm_pkt_i.valid;

    if (rm_pkt_i.valid) begin
      mask_d[FLD_PC]        = core_pkt_i.pc_rdata != rm_pkt_i.pc_rdata;
      mask_d[FLD_INSN]      = core_pkt_i.insn != rm_pkt_i.insn;
      mask_d[FLD_TRAP]      = core_pkt_i.trap != rm_pkt_i.trap;
      mask_d[FLD_HALT]      = core_pkt_i.halt != rm_pkt_i.halt;
      mask_d[FLD_DBG]       = core_pkt_i.dbg != rm_pkt_i.dbg;
      mask_d[FLD_DBG_MODE]  = core_pkt_i.dbg_mode != rm_pkt_i.dbg_mode;
      mask_d[FLD_NMIP]      = core_pkt_i.nmip != rm_pkt_i.nmip;
      mask_d[FLD_INTR]      = core_pkt_i.intr != rm_pkt_i.intr;
      mask_d[FLD_MODE]      = core_pkt_i.mode != rm_pkt_i.mode;
      mask_d[FLD_RD1_ADDR]  = core_pkt_i.rd1_addr != rm_pkt_i.rd1_addr;
      mask_d[FLD_MEM_RMASK] = core_pkt_i.mem_rmask[3:0] != rm_pkt_i.mem_rmask[3:0];
      mask_d[FLD_MEM_WMASK] = core_pkt_i.mem_wmask[3:0] != rm_pkt_i.mem_wmask[3:0];
      mask_d[FLD_PC_WDATA]  = core_pkt_i.pc_wdata != rm_pkt_i.pc_wdata;

      // x0 writes carry no meaningful data
      if (rm_pkt_i.rd1_addr != '0) begin
        mask_d[FLD_RD1_WDATA] = core_pkt_i.rd1_wdata != rm_pkt_i.rd1_wdata;
      end
      if (core_rd || core_wr) begin
        mask_d[FLD_MEM_ADDR] = core_pkt_i.mem_addr != rm_pkt_i.mem_addr;
      end
      if (core_wr) begin
        mask_d[FLD_MEM_WDATA] = core_pkt_i.mem_wdata != rm_pkt_i.mem_wdata;
      end
      if (core_rd) begin
        mask_d[FLD_MEM_RDATA] = core_pkt_i.mem_rdata != rm_pkt_i.mem_rdata;
      end
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (rst_i) begin
      result_o.valid <= 1'b0;
      result_o.mask  <= '0;
    end else begin
      result_o.valid <= cmp_valid;
      result_o.mask  <= mask_d;
    end
    result_o.pc <= core_pkt_i.pc_rdata;
  end

  // mask bits that need a model packet to exist
  always_comb begin
    data_mask = result_o.mask;
    data_mask[FLD_VALID] = 1'b0;
  end

  a_field_needs_model: assert property (
    @(posedge rvfi_core) disable iff (rst_i)
    (result_o.valid && data_mask != '0) |-> $past(rm_pkt_i.valid)
  );

  a_idle_mask_zero: assert property (
    @(posedge rvfi_core) disable iff (rst_i)
    !result_o.valid |-> result_o.mask == '0
  );

endmodule

/* src/rvfi_mismatch_log.sv */
/*
  Counts compared and mismatching retirements and keeps the first failing
  compare result until reset. error_o stays high once a mismatch was seen.
*/
module rvfi_mismatch_log
  import rvfi_cmp_pkg::*;
(
  input  logic             rvfi_core,
  input  logic             rst_i,
  input  cmp_result_t      result_i,
  output logic [CNT_W-1:0] compared_cnt_o,
  output logic [CNT_W-1:0] mismatch_cnt_o,
  output logic             error_o,
  output cmp_result_t      first_err_o
);

  log_state_e state_q;
  log_state_e state_d;
  logic       is_mismatch;
  logic       latch_first;

  assign is_mismatch = result_i.valid && (result_i.mask != '0);
  assign latch_first = (state_q == LOG_CLEAN) && is_mismatch;

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOG_CLEAN: begin
        if (is_mismatch) begin
          state_d = LOG_FAULTED;
        end
      end
      // only reset leaves the faulted state
      LOG_FAULTED: state_d = LOG_FAULTED;
      default:     state_d = LOG_CLEAN;
    endcase
  end

  always_ff @(posedge rvfi_core) begin
    if (rst_i) begin
      state_q <= LOG_CLEAN;
    end else begin
      state_q <= state_d;
    end
  end

  assign error_o = (state_q == LOG_FAULTED);

  // counters saturate instead of wrapping
  always_ff @(posedge rvfi_core) begin
    if (rst_i) begin
      compared_cnt_o <= '0;
      mismatch_cnt_o <= '0;
    end else begin
      if (result_i.valid && compared_cnt_o != '1) begin
        compared_cnt_o <= compared_cnt_o + 1'b1;
      end
      if (is_mismatch && mismatch_cnt_o != '1) begin
        mismatch_cnt_o <= mismatch_cnt_o + 1'b1;
      end
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (rst_i) begin
      first_err_o <= '0;
    end else if (latch_first) begin
      first_err_o <= result_i;
    end
  end

  a_cnt_order: assert property (
    @(posedge rvfi_core) disable iff (rst_i)
    mismatch_cnt_o <= compared_cnt_o
  );

endmodule

/* src/rvfi_checker_top.sv */
/*
  RVFI retirement checker: aligns the core stream to the reference model
  stream, compares each retirement and logs the disagreements.
*/
module rvfi_checker_top
  import rvfi_cmp_pkg::*;
(
  input  logic             rvfi_core,
  input  logic             rst_i,
  input  rvfi_pkt_t        core_pkt_i,
  input  rvfi_pkt_t        rm_pkt_i,
  output cmp_result_t      mismatch_o,
  output logic [CNT_W-1:0] compared_cnt_o,
  output logic [CNT_W-1:0] mismatch_cnt_o,
  output logic             error_o,
  output cmp_result_t      first_err_o
);

  rvfi_pkt_t aligned_pkt;

  // core stream leads the model by one cycle
  rvfi_core_align u_align (
    .rvfi_core     (rvfi_core),
    .rst_i         (rst_i),
    .core_pkt_i    (core_pkt_i),
    .aligned_pkt_o (aligned_pkt)
  );

  rvfi_field_cmp u_cmp (
    .rvfi_core  (rvfi_core),
    .rst_i      (rst_i),
    .core_pkt_i (aligned_pkt),
    .rm_pkt_i   (rm_pkt_i),
    .result_o   (mismatch_o)
  );

  // log sees the same registered result that leaves on mismatch_o
  rvfi_mismatch_log u_log (
    .rvfi_core      (rvfi_core),
    .rst_i          (rst_i),
    .result_i       (mismatch_o),
    .compared_cnt_o (compared_cnt_o),
    .mismatch_cnt_o (mismatch_cnt_o),
    .error_o        (error_o),
    .first_err_o    (first_err_o)
  );

endmodule

/* testbench/tb_rvfi_checker.sv */
/*
  Random self-checking testbench for the RVFI retirement checker. Core packets
  are drawn from an LFSR and the model stream is a corrupted copy one cycle later.
  A model of the compare rules predicts mismatch_o, the counters and the first failure.
*/
module tb_rvfi_checker
  import rvfi_cmp_pkg::*;
;

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 90;
  localparam logic [31:0] SEED  = 32'h8ebaac36;

  logic             rvfi_core;
  logic             rst_i;
  rvfi_pkt_t        core_pkt_i;
  rvfi_pkt_t        rm_pkt_i;
  cmp_result_t      mismatch_o;
  logic [CNT_W-1:0] compared_cnt_o;
  logic [CNT_W-1:0] mismatch_cnt_o;
  logic             error_o;
  cmp_result_t      first_err_o;

  logic [31:0]      lfsr_q;
  int               cycle_cnt;
  rvfi_pkt_t        prev_core;
  rvfi_pkt_t        core_new;
  rvfi_pkt_t        rm_new;
  cmp_result_t      exp_q[$];
  cmp_result_t      exp_now;
  logic [CNT_W-1:0] exp_cmp_cnt;
  logic [CNT_W-1:0] exp_mis_cnt;
  logic             exp_faulted;
  cmp_result_t      exp_first;

  rvfi_checker_top dut (
    .rvfi_core      (rvfi_core),
    .rst_i          (rst_i),
    .core_pkt_i     (core_pkt_i),
    .rm_pkt_i       (rm_pkt_i),
    .mismatch_o     (mismatch_o),
    .compared_cnt_o (compared_cnt_o),
    .mismatch_cnt_o (mismatch_cnt_o),
    .error_o        (error_o),
    .first_err_o    (first_err_o)
  );

  initial begin
    rvfi_core = 1'b0;
    forever #2 rvfi_core = ~rvfi_core;
  end

  always @(posedge rvfi_core) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic rvfi_pkt_t random_pkt();
    rvfi_pkt_t p;
    p = '0;
    // idle one cycle in four
    p.valid     = rand_bits(2) != 0;
    p.pc_rdata  = rand_bits(32);
    p.insn      = rand_bits(32);
    p.trap      = rand_bits(1);
    p.halt      = rand_bits(1);
    p.dbg       = rand_bits(3);
    p.dbg_mode  = rand_bits(1);
    p.nmip      = rand_bits(2);
    p.intr      = rand_bits(11);
    p.mode      = rand_bits(2);
    // x0 and memory-free instructions are common so the qualifiers get exercised
    p.rd1_addr  = (rand_bits(2) == 0) ? '0 : rand_bits(5);
    p.rd1_wdata = rand_bits(32);
    p.mem_addr  = rand_bits(32);
    p.mem_rmask = rand_bits(1) ? rand_bits(4) : '0;
    p.mem_wmask = rand_bits(1) ? rand_bits(4) : '0;
    p.mem_wdata = rand_bits(32);
    p.mem_rdata = rand_bits(32);
    p.pc_wdata  = rand_bits(32);
    return p;
  endfunction

  function automatic rvfi_pkt_t corrupt_pkt(input rvfi_pkt_t c);
    rvfi_pkt_t m;
    int        sel;
    m = c;
    if (rand_bits(3) == 0) begin
      sel = rand_bits(5) % NUM_FIELDS;
      case (rvfi_field_e'(sel))
        FLD_VALID:     m.valid        = ~m.valid;
        FLD_PC:        m.pc_rdata[0]  = ~m.pc_rdata[0];
        FLD_INSN:      m.insn[0]      = ~m.insn[0];
        FLD_TRAP:      m.trap         = ~m.trap;
        FLD_HALT:      m.halt         = ~m.halt;
        FLD_DBG:       m.dbg[0]       = ~m.dbg[0];
        FLD_DBG_MODE:  m.dbg_mode     = ~m.dbg_mode;
        FLD_NMIP:      m.nmip[0]      = ~m.nmip[0];
        FLD_INTR:      m.intr[0]      = ~m.intr[0];
        FLD_MODE:      m.mode[0]      = ~m.mode[0];
        FLD_RD1_ADDR:  m.rd1_addr[0]  = ~m.rd1_addr[0];
        FLD_RD1_WDATA: m.rd1_wdata[0] = ~m.rd1_wdata[0];
        FLD_MEM_RMASK: m.mem_rmask[0] = ~m.mem_rmask[0];
        FLD_MEM_WMASK: m.mem_wmask[0] = ~m.mem_wmask[0];
        FLD_MEM_ADDR:  m.mem_addr[0]  = ~m.mem_addr[0];
        FLD_MEM_WDATA: m.mem_wdata[0] = ~m.mem_wdata[0];
        FLD_MEM_RDATA: m.mem_rdata[0] = ~m.mem_rdata[0];
        default:       m.pc_wdata[0]  = ~m.pc_wdata[0];
      endcase
    end
    if (rand_bits(4) == 0) begin
      m.valid = 1'b0;
    end
    return m;
  endfunction

  // expected compare outcome for an aligned core packet and a model packet
  function automatic cmp_result_t expect_result(input rvfi_pkt_t c, input rvfi_pkt_t m);
    cmp_result_t r;
    logic        rd;
    logic        wr;
    r = '0;
    r.valid = c.valid || m.valid;
    r.pc = c.pc_rdata;
    rd = c.mem_rmask != 0;
    wr = c.mem_wmask != 0;
    r.mask[FLD_VALID] = c.valid && !m.valid;
    if (m.valid) begin
      r.mask[FLD_PC]        = c.pc_rdata != m.pc_rdata;
      r.mask[FLD_INSN]      = c.insn != m.insn;
      r.mask[FLD_TRAP]      = c.trap != m.trap;
      r.mask[FLD_HALT]      = c.halt != m.halt;
      r.mask[FLD_DBG]       = c.dbg != m.dbg;
      r.mask[FLD_DBG_MODE]  = c.dbg_mode != m.dbg_mode;
      r.mask[FLD_NMIP]      = c.nmip != m.nmip;
      r.mask[FLD_INTR]      = c.intr != m.intr;
      r.mask[FLD_MODE]      = c.mode != m.mode;
      r.mask[FLD_RD1_ADDR]  = c.rd1_addr != m.rd1_addr;
      r.mask[FLD_MEM_RMASK] = c.mem_rmask != m.mem_rmask;
      r.mask[FLD_MEM_WMASK] = c.mem_wmask != m.mem_wmask;
      r.mask[FLD_PC_WDATA]  = c.pc_wdata != m.pc_wdata;
      r.mask[FLD_RD1_WDATA] = (m.rd1_addr != 0) && (c.rd1_wdata != m.rd1_wdata);
      r.mask[FLD_MEM_ADDR]  = (rd || wr) && (c.mem_addr != m.mem_addr);
      r.mask[FLD_MEM_WDATA] = wr && (c.mem_wdata != m.mem_wdata);
      r.mask[FLD_MEM_RDATA] = rd && (c.mem_rdata != m.mem_rdata);
    end
    return r;
  endfunction

  task automatic check_result(input string name, input cmp_result_t exp,
                              input cmp_result_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "compare result differs from the model");
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "counter differs from the model");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "flag differs from the model");
    end
  endtask

  initial begin
    rst_i       = 1'b1;
    core_pkt_i  = '0;
    rm_pkt_i    = '0;
    lfsr_q      = SEED;
    cycle_cnt   = 0;
    prev_core   = '0;
    exp_cmp_cnt = '0;
    exp_mis_cnt = '0;
    exp_faulted = 1'b0;
    exp_first   = '0;
    repeat (RESET_CYCLES) @(posedge rvfi_core);
    rst_i <= 1'b0;
    @(negedge rvfi_core);
    check_flag("reset_result_valid", 1'b0, mismatch_o.valid);
    check_flag("reset_error", 1'b0, error_o);
    check_count("reset_compared_cnt", '0, compared_cnt_o);
    check_count("reset_mismatch_cnt", '0, mismatch_cnt_o);

    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(posedge rvfi_core);
      core_new = random_pkt();
      // model packet describes the core packet of the previous cycle
      rm_new = corrupt_pkt(prev_core);
      core_pkt_i <= core_new;
      rm_pkt_i   <= rm_new;
      exp_q.push_back(expect_result(prev_core, rm_new));
      prev_core = core_new;
      @(negedge rvfi_core);
      if (exp_q.size() > 1) begin
        exp_now = exp_q.pop_front();
        check_result("mismatch_o", exp_now, mismatch_o);
        // log outputs trail mismatch_o by one cycle
        check_count("compared_cnt", exp_cmp_cnt, compared_cnt_o);
        check_count("mismatch_cnt", exp_mis_cnt, mismatch_cnt_o);
        check_flag("error", exp_faulted, error_o);
        check_result("first_err", exp_first, first_err_o);
        if (exp_now.valid) begin
          exp_cmp_cnt = exp_cmp_cnt + 1'b1;
        end
        if (exp_now.valid && exp_now.mask != 0) begin
          exp_mis_cnt = exp_mis_cnt + 1'b1;
          if (!exp_faulted) begin
            exp_faulted = 1'b1;
            exp_first   = exp_now;
          end
        end
      end
    end

    if (exp_mis_cnt == 0) begin
      $display("the stimulus produced no mismatch, so error logging was not exercised");
      $display("TEST FAIL");
      $fatal(1, "stimulus did not reach the faulted state");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* sources.f */
src/rvfi_cmp_pkg.sv
src/rvfi_core_align.sv
src/rvfi_field_cmp.sv
src/rvfi_mismatch_log.sv
src/rvfi_checker_top.sv
testbench/tb_rvfi_checker.sv
